// ==== Makefile ====
VERILATOR = verilator
VFLAGS = --binary --timing --assert -j 0
TOP = tb_mem_top
RTL_TOP = mem_top
FILELIST = sim.f
OBJ_DIR = obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	@out=$$(./$(OBJ_DIR)/V$(TOP)); echo "$$out"; echo "$$out" | grep -qx "All tests passed"

lint:
	$(VERILATOR) --lint-only -Wall --timing --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

// ==== cache_array.sv ====
`timescale 1ns/1ps

module cache_array (
	input logic clk,
	input logic rst_n,
	input mem_pkg::index_t index,
	input mem_pkg::offset_t offset,
	output mem_pkg::tag_t lookup_tag,
	output logic lookup_valid,
	output logic lookup_dirty,
	output mem_pkg::line_t lookup_line,
	input logic word_we,
	input mem_pkg::word_t word_data,
	input logic fill_we,
	input mem_pkg::tag_t fill_tag,
	input mem_pkg::line_t fill_line
);

	// Per-line state bits
	logic [mem_pkg::CACHE_LINES-1:0] valid_q;
	logic [mem_pkg::CACHE_LINES-1:0] dirty_q;
	// Tag and data storage
	mem_pkg::tag_t tag_q [mem_pkg::CACHE_LINES];
	mem_pkg::line_t data_q [mem_pkg::CACHE_LINES];

	// Combinational lookup by index
	assign lookup_tag = tag_q[index];
	assign lookup_valid = valid_q[index];
	assign lookup_dirty = dirty_q[index];
	assign lookup_line = data_q[index];

	// Valid and dirty bits
	always_ff @(posedge clk, negedge rst_n) begin
		if (!rst_n) begin
			valid_q <= '0;
			dirty_q <= '0;
		end else if (fill_we) begin
			// Fresh line from host is clean
			valid_q[index] <= 1'b1;
			dirty_q[index] <= 1'b0;
		end else if (word_we) begin
			dirty_q[index] <= 1'b1;
		end
	end

	// Tag and line contents
	always_ff @(posedge clk) begin
		if (fill_we) begin
			tag_q[index] <= fill_tag;
			data_q[index] <= fill_line;
		end else if (word_we) begin
			// Single word update within the line
			data_q[index][32*offset +: 32] <= word_data;
		end
	end

endmodule

// ==== host_line_mem.sv ====
`timescale 1ns/1ps

module host_line_mem (
	input logic clk,
	input logic rst_n,
	input mem_pkg::host_op_t host_op,
	input mem_pkg::addr_t host_addr,
	input mem_pkg::line_t host_wdata,
	output mem_pkg::line_t host_rdata,
	output logic rd_valid,
	output logic tx_done
);

	localparam int LINE_BITS = $clog2(mem_pkg::HOST_LINES);
	localparam int CNT_BITS = $clog2(mem_pkg::HOST_LATENCY + 1);
	localparam logic [CNT_BITS-1:0] CNT_LAST = CNT_BITS'(mem_pkg::HOST_LATENCY - 1);

	mem_pkg::line_t mem_q [mem_pkg::HOST_LINES];
	logic [LINE_BITS-1:0] line_sel;
	logic [CNT_BITS-1:0] cnt_q;
	// Cycle after a response, op still being released
	logic ign_q;
	logic active;
	logic respond;

	// Address wraps modulo the host size
	assign line_sel = host_addr[6 +: LINE_BITS];
	assign active = host_op != mem_pkg::HOST_IDLE && !rd_valid && !tx_done && !ign_q;
	assign respond = active && cnt_q == CNT_LAST;

	// Known pattern, word at byte a holds a ^ INIT_PATTERN
	initial begin
		for (int l = 0; l < mem_pkg::HOST_LINES; l++) begin
			for (int w = 0; w < mem_pkg::WORDS_PER_LINE; w++) begin
				mem_q[l][32*w +: 32] = 32'(l * mem_pkg::WORDS_PER_LINE * 4 + w * 4)
					^ mem_pkg::INIT_PATTERN;
			end
		end
	end

	// Latency counter and response strobes
	always_ff @(posedge clk, negedge rst_n) begin
		if (!rst_n) begin
			cnt_q <= '0;
			rd_valid <= 1'b0;
			tx_done <= 1'b0;
			ign_q <= 1'b0;
		end else begin
			rd_valid <= respond && host_op == mem_pkg::HOST_READ;
			tx_done <= respond && host_op == mem_pkg::HOST_WRITE;
			ign_q <= rd_valid | tx_done;
			if (active && !respond)
				cnt_q <= cnt_q + 1'b1;
			else
				cnt_q <= '0;
		end
	end

	// Write commits as tx_done rises, read data lands with rd_valid
	always @(posedge clk) begin
		if (respond) begin
			if (host_op == mem_pkg::HOST_WRITE)
				mem_q[line_sel] <= host_wdata;
			else
				host_rdata <= mem_q[line_sel];
		end
	end

endmodule

// ==== mem_pkg.sv ====
package mem_pkg;

	// Basic data widths
	typedef logic [31:0] word_t;
	typedef logic [31:0] addr_t;
	typedef logic [511:0] line_t;

	// Cache geometry
	localparam int WORDS_PER_LINE = 16;
	localparam int CACHE_LINES = 8;

	// Address split: tag 31..9, index 8..6, word offset 5..2
	typedef logic [2:0] index_t;
	typedef logic [22:0] tag_t;
	typedef logic [3:0] offset_t;

	// Host line port operations
	typedef enum logic [1:0] {
		HOST_IDLE = 2'd0,
		HOST_READ = 2'd1,
		HOST_WRITE = 2'd2
	} host_op_t;

	// Host memory size in lines, 4 KB total
	localparam int HOST_LINES = 64;
	// Cycles from op presented to response strobe
	localparam int HOST_LATENCY = 4;
	// Initial word at byte address a is a ^ INIT_PATTERN
	localparam logic [31:0] INIT_PATTERN = 32'h5a5a_0000;

	// Store here kicks the FPU instead of the cache
	localparam logic [31:0] FPU_START_ADDR = 32'h1000_0000;

	// Request from the EX/MEM pipeline register
	typedef struct packed {
		addr_t addr;
		word_t data;
		logic wr;
	} mem_req_t;

endpackage

// ==== mem_system.sv ====
`timescale 1ns/1ps

module mem_system (
	input logic clk,
	input logic rst_n,
	input mem_pkg::mem_req_t mem_req,
	input logic en,
	output mem_pkg::word_t rd_data,
	output logic done,
	output mem_pkg::host_op_t host_op,
	output mem_pkg::addr_t host_addr,
	output mem_pkg::line_t host_wdata,
	input mem_pkg::line_t host_rdata,
	input logic rd_valid,
	input logic tx_done
);

	// Controller states
	typedef enum logic [2:0] {
		IDLE,
		COMPARE,
		WRITEBACK,
		FILL,
		DONE
	} state_t;

	state_t state_q;
	state_t state_d;

	// Request address fields
	mem_pkg::tag_t req_tag;
	mem_pkg::index_t req_index;
	mem_pkg::offset_t req_offset;

	// Cache lookup results
	mem_pkg::tag_t lookup_tag;
	logic lookup_valid;
	logic lookup_dirty;
	mem_pkg::line_t lookup_line;

	logic compare_now;
	logic hit;
	logic word_we;
	logic fill_we;
	// Host responded last cycle so op drops for one cycle
	logic resp_q;

	assign req_tag = mem_req.addr[31:9];
	assign req_index = mem_req.addr[8:6];
	assign req_offset = mem_req.addr[5:2];

	cache_array u_cache (
		.clk(clk),
		.rst_n(rst_n),
		.index(req_index),
		.offset(req_offset),
		.lookup_tag(lookup_tag),
		.lookup_valid(lookup_valid),
		.lookup_dirty(lookup_dirty),
		.lookup_line(lookup_line),
		.word_we(word_we),
		.word_data(mem_req.data),
		.fill_we(fill_we),
		.fill_tag(req_tag),
		.fill_line(host_rdata)
	);

	// Tag check on a new request or right after a fill
	assign compare_now = (state_q == IDLE && en) || state_q == COMPARE;
	assign hit = lookup_valid && lookup_tag == req_tag;
	// Store hit writes the word and the array sets dirty
	assign word_we = compare_now && hit && mem_req.wr;
	// Install the fetched line on the read strobe
	assign fill_we = state_q == FILL && rd_valid;

	always_comb begin
		state_d = state_q;
		case (state_q)
			IDLE, COMPARE: begin
				if (compare_now) begin
					if (hit)
						state_d = DONE;
					else if (lookup_valid && lookup_dirty)
						state_d = WRITEBACK;
					else
						state_d = FILL;
				end
			end
			WRITEBACK: begin
				if (tx_done)
					state_d = FILL;
			end
			FILL: begin
				// Recheck as a hit once installed
				if (rd_valid)
					state_d = COMPARE;
			end
			DONE: state_d = IDLE;
			default: state_d = IDLE;
		endcase
	end

	always_ff @(posedge clk, negedge rst_n) begin
		if (!rst_n) begin
			state_q <= IDLE;
			resp_q <= 1'b0;
		end else begin
			state_q <= state_d;
			resp_q <= rd_valid | tx_done;
		end
	end

	// Host port held steady by the state until the response
	always_comb begin
		host_op = mem_pkg::HOST_IDLE;
		host_addr = {req_tag, req_index, 6'b0};
		if (!resp_q) begin
			if (state_q == WRITEBACK) begin
				host_op = mem_pkg::HOST_WRITE;
				// Victim address from the stored tag
				host_addr = {lookup_tag, req_index, 6'b0};
			end else if (state_q == FILL) begin
				host_op = mem_pkg::HOST_READ;
			end
		end
	end

	// Victim line is always presented and only sampled on a write
	assign host_wdata = lookup_line;

	assign done = state_q == DONE;
	// Line is resident in the done cycle
	assign rd_data = lookup_line[32*req_offset +: 32];

	// Host request must not move before its response
	a_host_stable: assert property (@(posedge clk) disable iff (!rst_n)
		(host_op != mem_pkg::HOST_IDLE && !rd_valid && !tx_done)
		|=> ($stable(host_op) && $stable(host_addr) && $stable(host_wdata)));

endmodule

// ==== mem_top.sv ====
`timescale 1ns/1ps

module mem_top (
	input logic clk,
	input logic rst_n,
	input mem_pkg::mem_req_t mem_req,
	input logic en,
	output mem_pkg::word_t rd_data,
	output logic done,
	output logic start_fpu
);

	// Host line port between stage and backing memory
	mem_pkg::host_op_t host_op;
	mem_pkg::addr_t host_addr;
	mem_pkg::line_t host_wdata;
	mem_pkg::line_t host_rdata;
	logic rd_valid;
	logic tx_done;

	memory u_memory (
		.clk(clk),
		.rst_n(rst_n),
		.mem_req(mem_req),
		.en(en),
		.rd_data(rd_data),
		.done(done),
		.start_fpu(start_fpu),
		.host_op(host_op),
		.host_addr(host_addr),
		.host_wdata(host_wdata),
		.host_rdata(host_rdata),
		.rd_valid(rd_valid),
		.tx_done(tx_done)
	);

	// Behavioural stand-in for the memory controller
	host_line_mem u_host (
		.clk(clk),
		.rst_n(rst_n),
		.host_op(host_op),
		.host_addr(host_addr),
		.host_wdata(host_wdata),
		.host_rdata(host_rdata),
		.rd_valid(rd_valid),
		.tx_done(tx_done)
	);

endmodule

// ==== memory.sv ====
`timescale 1ns/1ps

module memory (
	input logic clk,
	input logic rst_n,
	input mem_pkg::mem_req_t mem_req,
	input logic en,
	output mem_pkg::word_t rd_data,
	output logic done,
	output logic start_fpu,
	output mem_pkg::host_op_t host_op,
	output mem_pkg::addr_t host_addr,
	output mem_pkg::line_t host_wdata,
	input mem_pkg::line_t host_rdata,
	input logic rd_valid,
	input logic tx_done
);

	logic fpu_store;
	logic cache_en;
	logic cache_done;

	// Store to the FPU start address never reaches the cache
	assign fpu_store = en && mem_req.wr && mem_req.addr == mem_pkg::FPU_START_ADDR;
	assign cache_en = en && !fpu_store;

	mem_system u_mem_system (
		.clk(clk),
		.rst_n(rst_n),
		.mem_req(mem_req),
		.en(cache_en),
		.rd_data(rd_data),
		.done(cache_done),
		.host_op(host_op),
		.host_addr(host_addr),
		.host_wdata(host_wdata),
		.host_rdata(host_rdata),
		.rd_valid(rd_valid),
		.tx_done(tx_done)
	);

	// Request is still held in the pulse cycle and must not fire again
	always_ff @(posedge clk, negedge rst_n) begin
		if (!rst_n)
			start_fpu <= 1'b0;
		else
			start_fpu <= fpu_store && !start_fpu;
	end

	// FPU store completes with its pulse
	assign done = cache_done | start_fpu;

	// Merged completion is one cycle, so the FPU pulse is too
	a_done_pulse: assert property (@(posedge clk) disable iff (!rst_n)
		done |=> !done);

endmodule

// ==== sim.f ====
mem_pkg.sv
cache_array.sv
mem_system.sv
memory.sv
host_line_mem.sv
mem_top.sv
tb_mem_top.sv

// ==== tb_mem_top.sv ====
`timescale 1ns/1ps

module tb_mem_top;

	logic clk;
	logic rst_n;
	mem_pkg::mem_req_t mem_req;
	logic en;
	mem_pkg::word_t rd_data;
	logic done;
	logic start_fpu;

	// Reference copy of the 4 KB host space, one entry per word
	mem_pkg::word_t model [1024];
	int errors;
	int accesses;
	// Sampled edges from en to done of the latest access
	int last_cycles;

	mem_top uut (
		.clk(clk),
		.rst_n(rst_n),
		.mem_req(mem_req),
		.en(en),
		.rd_data(rd_data),
		.done(done),
		.start_fpu(start_fpu)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	task automatic report_mismatch(input string name, input logic [31:0] exp,
			input logic [31:0] act);
		$display("ERROR %s: expected %h, actual %h", name, exp, act);
		errors++;
	endtask

	task automatic end_run();
		$display("Accesses: %0d, errors: %0d", accesses, errors);
		if (errors == 0)
			$display("All tests passed");
		else
			$display("Some tests failed");
		$finish;
	endtask

	// Holds one request until done, then checks it against the model
	task automatic access(input string name, input logic wr, input mem_pkg::addr_t addr,
			input mem_pkg::word_t data);
		logic is_fpu;
		logic seen;
		int pulses;
		mem_pkg::word_t got;
		is_fpu = wr && addr == mem_pkg::FPU_START_ADDR;
		seen = 1'b0;
		pulses = 0;
		got = '0;
		last_cycles = 0;
		mem_req.addr = addr;
		mem_req.data = data;
		mem_req.wr = wr;
		en = 1'b1;
		// Sample just after each edge, outputs settled by then
		while (!seen && last_cycles < 200) begin
			@(posedge clk);
			#1;
			last_cycles++;
			if (start_fpu)
				pulses++;
			if (done) begin
				seen = 1'b1;
				got = rd_data;
			end
		end
		en = 1'b0;
		if (!seen) begin
			$display("ERROR %s: done never arrived within 200 cycles of en", name);
			errors++;
			end_run();
		end else begin
			accesses++;
			if (is_fpu) begin
				// Pulse and done together, one cycle after en
				if (pulses != 1)
					report_mismatch({name, " start_fpu pulses"}, 1, pulses);
				if (last_cycles != 1)
					report_mismatch({name, " latency"}, 1, last_cycles);
			end else begin
				if (pulses != 0)
					report_mismatch({name, " start_fpu pulses"}, 0, pulses);
				if (!wr && got !== model[addr[11:2]])
					report_mismatch(name, model[addr[11:2]], got);
				if (wr)
					model[addr[11:2]] = data;
			end
			// Idle cycle between requests
			@(posedge clk);
			#1;
			if (start_fpu)
				report_mismatch({name, " start_fpu after done"}, 0, start_fpu);
			if (done)
				report_mismatch({name, " done after done"}, 0, done);
		end
	endtask

	initial begin
		mem_pkg::addr_t addr_a;
		mem_pkg::addr_t addr_b;
		mem_pkg::addr_t addr;
		int sel;
		void'($urandom(32'hbfb3));
		errors = 0;
		accesses = 0;
		last_cycles = 0;
		rst_n = 1'b0;
		en = 1'b0;
		mem_req = '0;
		// Host word at byte a starts as a ^ pattern, a wrapped to 4 KB
		for (int i = 0; i < 1024; i++)
			model[i] = 32'(i * 4) ^ mem_pkg::INIT_PATTERN;
		repeat (10) @(posedge clk);
		#1;
		rst_n = 1'b1;
		if (done)
			report_mismatch("reset done", 0, done);
		if (start_fpu)
			report_mismatch("reset start_fpu", 0, start_fpu);

		// Cold loads see the initial pattern
		access("init_load_lo", 1'b0, 32'h0000_0010, '0);
		access("init_load_top", 1'b0, 32'h0000_0ffc, '0);
		access("init_load_wrap", 1'b0, 32'h1234_5670, '0);

		// Store then load, second access is a hit
		access("store_load_st", 1'b1, 32'h0000_0104, 32'hcafe_0001);
		access("store_load_ld", 1'b0, 32'h0000_0104, '0);
		if (last_cycles != 1)
			report_mismatch("hit latency", 1, last_cycles);

		// Same index, other tag, dirty victim goes back to host
		addr_a = 32'h0000_0088;
		addr_b = addr_a + 32'h200;
		access("evict_store_a", 1'b1, addr_a, 32'h1111_2222);
		access("evict_load_b", 1'b0, addr_b, '0);
		access("evict_reload_a", 1'b0, addr_a, '0);
		access("evict_reload_b", 1'b0, addr_b, '0);

		// FPU kick, a neighbouring plain store, then a load of the kick address
		access("fpu_start", 1'b1, mem_pkg::FPU_START_ADDR, 32'hdead_beef);
		access("fpu_neighbour_store", 1'b1, 32'h1000_0004, 32'h0bad_f00d);
		access("fpu_addr_load", 1'b0, mem_pkg::FPU_START_ADDR, '0);

		// Five tags over two indexes, tag 4 aliases host line 0
		for (int n = 0; n < 400; n++) begin
			sel = int'($urandom % 5);
			if (sel == 4)
				addr = mem_pkg::FPU_START_ADDR;
			else
				addr = 32'(sel) << 9;
			addr = addr | (32'($urandom % 2) << 6) | (32'($urandom % 4) << 2);
			if ($urandom % 12 == 0)
				access("rand_fpu_start", 1'b1, mem_pkg::FPU_START_ADDR, $urandom);
			else if ($urandom % 2 == 0)
				access("rand_store", 1'b1, addr, $urandom);
			else
				access("rand_load", 1'b0, addr, '0);
		end

		end_run();
	end

endmodule
